// File: logic/mastermind_params.svh
`ifndef MASTERMIND_PARAMS_SVH
`define MASTERMIND_PARAMS_SVH

// Longest row the judge can score
`define MAX_PINS 8

// Bits per pin color, 16 colors
`define PIN_COLOR_W 4

// Number of distinct pin colors
`define PIN_COLORS (1 << `PIN_COLOR_W)

// Holds 0 up to MAX_PINS
`define PIN_COUNT_W 4

// Guess counter, saturates at all ones
`define GUESS_COUNT_W 8

`endif

// File: logic/mastermind_pkg.sv
`include "mastermind_params.svh"

package mastermind_pkg;

	typedef logic [`PIN_COLOR_W-1:0]           pin_color_t;
	typedef logic [`MAX_PINS*`PIN_COLOR_W-1:0] pin_row_t;   // Pin 0 in the low bits
	typedef logic [`PIN_COUNT_W-1:0]           pin_count_t;
	typedef logic [`GUESS_COUNT_W-1:0]         guess_count_t;

	typedef enum logic [1:0] {
		GAME_PLAYING,
		GAME_SOLVED,
		GAME_LOST
	} game_state_t;

	// Color of one position in a row
	function automatic pin_color_t pin_at(input pin_row_t row, input int unsigned idx);
		return row[idx*`PIN_COLOR_W +: `PIN_COLOR_W];
	endfunction

	// One bit per position that takes part in the game
	function automatic logic [`MAX_PINS-1:0] active_mask(input pin_count_t pins_count);
		logic [`MAX_PINS-1:0] mask;
		for (int i = 0; i < `MAX_PINS; i++) begin
			mask[i] = (i < int'(pins_count));
		end
		return mask;
	endfunction

endpackage

// File: logic/exact_matcher.sv
`timescale 1ns/1ps
`include "mastermind_params.svh"

module exact_matcher (
	input  logic                      CLK_PLL,
	input  logic                      reset,
	input  logic                      guess_valid,
	input  mastermind_pkg::pin_row_t   guess,
	input  mastermind_pkg::pin_row_t   secret,
	input  mastermind_pkg::pin_count_t pins_count,
	output logic                      exact_valid,
	output mastermind_pkg::pin_count_t exact_count
);
	import mastermind_pkg::*;

	logic [`MAX_PINS-1:0] match_d;
	logic [`MAX_PINS-1:0] match_q;   // Stage 1 mask
	logic                 s1_valid;
	pin_count_t           hits_d;

	// Unused positions never match, whatever their colors
	always_comb begin
		for (int i = 0; i < `MAX_PINS; i++) begin
			match_d[i] = (pin_at(guess, i) == pin_at(secret, i));
		end
		match_d = match_d & active_mask(pins_count);
	end

	// Population count of the mask
	always_comb begin
		hits_d = '0;
		for (int i = 0; i < `MAX_PINS; i++) begin
			hits_d = hits_d + pin_count_t'(match_q[i]);
		end
	end

	always_ff @(posedge CLK_PLL) begin
		if (reset) begin
			s1_valid    <= 1'b0;
			exact_valid <= 1'b0;
		end else begin
			s1_valid    <= guess_valid;
			exact_valid <= s1_valid;
		end
	end

	always_ff @(posedge CLK_PLL) begin
		if (guess_valid)
			match_q <= match_d;
		if (s1_valid)
			exact_count <= hits_d;
	end

endmodule

// File: logic/color_tally.sv
`timescale 1ns/1ps
`include "mastermind_params.svh"

module color_tally (
	input  logic                      CLK_PLL,
	input  logic                      reset,
	input  logic                      guess_valid,
	input  mastermind_pkg::pin_row_t   guess,
	input  mastermind_pkg::pin_row_t   secret,
	input  mastermind_pkg::pin_count_t pins_count,
	output logic                      common_valid,
	output mastermind_pkg::pin_count_t common_count
);
	import mastermind_pkg::*;

	// One count per color, guess side and secret side
	pin_count_t guess_hist_d  [`PIN_COLORS];
	pin_count_t secret_hist_d [`PIN_COLORS];
	pin_count_t guess_hist_q  [`PIN_COLORS];
	pin_count_t secret_hist_q [`PIN_COLORS];

	logic [`MAX_PINS-1:0] active;
	logic                 s1_valid;
	pin_count_t           common_d;

	assign active = active_mask(pins_count);

	// Stage 1 histograms over the active positions only
	always_comb begin
		for (int c = 0; c < `PIN_COLORS; c++) begin
			guess_hist_d[c]  = '0;
			secret_hist_d[c] = '0;
			for (int i = 0; i < `MAX_PINS; i++) begin
				if (active[i] && pin_at(guess, i) == pin_color_t'(c))
					guess_hist_d[c] = guess_hist_d[c] + 1'b1;
				if (active[i] && pin_at(secret, i) == pin_color_t'(c))
					secret_hist_d[c] = secret_hist_d[c] + 1'b1;
			end
		end
	end

	// Taking the smaller count per color means a pin is paired at most once,
	// so a color guessed twice against one secret pin scores a single match
	always_comb begin
		common_d = '0;
		for (int c = 0; c < `PIN_COLORS; c++) begin
			if (guess_hist_q[c] < secret_hist_q[c])
				common_d = common_d + guess_hist_q[c];
			else
				common_d = common_d + secret_hist_q[c];
		end
	end

	always_ff @(posedge CLK_PLL) begin
		if (reset) begin
			s1_valid     <= 1'b0;
			common_valid <= 1'b0;
		end else begin
			s1_valid     <= guess_valid;
			common_valid <= s1_valid;
		end
	end

	always_ff @(posedge CLK_PLL) begin
		if (guess_valid) begin
			for (int c = 0; c < `PIN_COLORS; c++) begin
				guess_hist_q[c]  <= guess_hist_d[c];
				secret_hist_q[c] <= secret_hist_d[c];
			end
		end
		if (s1_valid)
			common_count <= common_d;   // Stage 2
	end

endmodule

// File: logic/hint_combiner.sv
`timescale 1ns/1ps

module hint_combiner (
	input  logic                        CLK_PLL,
	input  logic                        reset,
	input  logic                        new_game,
	input  logic                        exact_valid,
	input  logic                        common_valid,
	input  mastermind_pkg::pin_count_t   exact_count,
	input  mastermind_pkg::pin_count_t   common_count,
	input  mastermind_pkg::pin_count_t   pins_count,
	input  mastermind_pkg::guess_count_t guesses_max,
	output logic                        hint_valid,
	output mastermind_pkg::pin_count_t   green,
	output mastermind_pkg::pin_count_t   yellow,
	output mastermind_pkg::guess_count_t guess_number,
	output mastermind_pkg::game_state_t  game_state
);
	import mastermind_pkg::*;

	game_state_t  state;
	guess_count_t guess_count;
	guess_count_t next_count;
	logic         flush;          // Drops the last result of the old game
	logic         result_valid;
	logic         scored;

	// A guess sampled one edge before new_game shows up one edge after it
	assign result_valid = exact_valid && common_valid && !flush;
	assign scored       = result_valid && state == GAME_PLAYING;

	// Saturating increment
	assign next_count = (guess_count == '1) ? guess_count : guess_count + 1'b1;

	always_ff @(posedge CLK_PLL) begin
		if (reset) begin
			state       <= GAME_PLAYING;
			guess_count <= '0;
			hint_valid  <= 1'b0;
			flush       <= 1'b0;
		end else if (new_game) begin
			state       <= GAME_PLAYING;
			guess_count <= '0;
			hint_valid  <= 1'b0;
			flush       <= 1'b1;
		end else begin
			flush      <= 1'b0;
			hint_valid <= scored;
			case (state)
				GAME_PLAYING: begin
					if (result_valid) begin
						guess_count <= next_count;
						if (exact_count == pins_count)
							state <= GAME_SOLVED;
						else if (next_count == guesses_max)
							state <= GAME_LOST;
					end
				end
				GAME_SOLVED, GAME_LOST: begin
					state <= state;   // Held until the next new_game
				end
				default: begin
					state <= GAME_PLAYING;
				end
			endcase
		end
	end

	// Common count never falls below the exact count
	always_ff @(posedge CLK_PLL) begin
		if (scored) begin
			green  <= exact_count;
			yellow <= common_count - exact_count;
		end
	end

	assign guess_number = guess_count;
	assign game_state   = state;

endmodule

// File: logic/mastermind_judge.sv
`timescale 1ns/1ps

module mastermind_judge (
	input  logic                        CLK_PLL,
	input  logic                        reset,
	input  logic                        new_game,
	input  mastermind_pkg::pin_count_t   pins_count,
	input  mastermind_pkg::guess_count_t guesses_max,
	input  mastermind_pkg::pin_row_t     secret,
	input  logic                        guess_valid,
	input  mastermind_pkg::pin_row_t     guess,
	output logic                        hint_valid,
	output mastermind_pkg::pin_count_t   green,
	output mastermind_pkg::pin_count_t   yellow,
	output mastermind_pkg::guess_count_t guess_number,
	output mastermind_pkg::game_state_t  game_state
);
	import mastermind_pkg::*;

	logic       exact_valid;
	pin_count_t exact_count;
	logic       common_valid;
	pin_count_t common_count;

	// Green path
	exact_matcher u_exact (
		.CLK_PLL     (CLK_PLL),
		.reset       (reset),
		.guess_valid (guess_valid),
		.guess       (guess),
		.secret      (secret),
		.pins_count  (pins_count),
		.exact_valid (exact_valid),
		.exact_count (exact_count)
	);

	// Any-position color matches
	color_tally u_tally (
		.CLK_PLL      (CLK_PLL),
		.reset        (reset),
		.guess_valid  (guess_valid),
		.guess        (guess),
		.secret       (secret),
		.pins_count   (pins_count),
		.common_valid (common_valid),
		.common_count (common_count)
	);

	hint_combiner u_combiner (
		.CLK_PLL      (CLK_PLL),
		.reset        (reset),
		.new_game     (new_game),
		.exact_valid  (exact_valid),
		.common_valid (common_valid),
		.exact_count  (exact_count),
		.common_count (common_count),
		.pins_count   (pins_count),
		.guesses_max  (guesses_max),
		.hint_valid   (hint_valid),
		.green        (green),
		.yellow       (yellow),
		.guess_number (guess_number),
		.game_state   (game_state)
	);

endmodule

// File: verification/mastermind_tb.sv
`timescale 1ns/1ps

module mastermind_tb;
	import mastermind_pkg::*;

	// One expected hint, queued in arrival order
	typedef struct packed {
		pin_count_t   green;
		pin_count_t   yellow;
		guess_count_t number;
		game_state_t  state;
		int unsigned  due;   // Cycle in which hint_valid must be high
	} hint_exp_t;

	logic         CLK_PLL;
	logic         reset;
	logic         new_game;
	pin_count_t   pins_count;
	guess_count_t guesses_max;
	pin_row_t     secret;
	logic         guess_valid;
	pin_row_t     guess;
	logic         hint_valid;
	pin_count_t   green;
	pin_count_t   yellow;
	guess_count_t guess_number;
	game_state_t  game_state;

	hint_exp_t    pending[$];
	int unsigned  cycle = 0;
	int unsigned  cycle_limit;

	mastermind_judge DUT (
		.CLK_PLL      (CLK_PLL),
		.reset        (reset),
		.new_game     (new_game),
		.pins_count   (pins_count),
		.guesses_max  (guesses_max),
		.secret       (secret),
		.guess_valid  (guess_valid),
		.guess        (guess),
		.hint_valid   (hint_valid),
		.green        (green),
		.yellow       (yellow),
		.guess_number (guess_number),
		.game_state   (game_state)
	);

	initial begin
		CLK_PLL = 1'b0;
		forever #2 CLK_PLL = ~CLK_PLL;
	end

	always @(posedge CLK_PLL)
		cycle <= cycle + 1;

	task automatic abort_run();
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic check_pins(input string name, input pin_count_t exp_val, input pin_count_t act);
		if (act !== exp_val) begin
			$display("ERR %0t %s expected %0d got %0d", $time, name, exp_val, act);
			abort_run();
		end
	endtask

	task automatic check_guesses(input string name, input guess_count_t exp_val,
			input guess_count_t act);
		if (act !== exp_val) begin
			$display("ERR %0t %s expected %0d got %0d", $time, name, exp_val, act);
			abort_run();
		end
	endtask

	task automatic check_state(input string name, input game_state_t exp_val,
			input game_state_t act);
		if (act !== exp_val) begin
			$display("ERR %0t %s expected %s got %s", $time, name, exp_val.name(), act.name());
			abort_run();
		end
	endtask

	// Last column of a G line, either a game state or drop
	function automatic logic decode_state(input logic [63:0] word, output game_state_t state,
			output logic drop);
		state = GAME_PLAYING;
		drop  = 1'b0;
		if (word == 64'("playing"))
			return 1'b1;
		if (word == 64'("solved")) begin
			state = GAME_SOLVED;
			return 1'b1;
		end
		if (word == 64'("lost")) begin
			state = GAME_LOST;
			return 1'b1;
		end
		drop = 1'b1;
		return word == 64'("drop");
	endfunction

	// Level inputs only change once every scored guess is out of the pipeline
	task automatic start_game(input pin_count_t pins, input guess_count_t max_guesses);
		@(posedge CLK_PLL);
		guess_valid <= 1'b0;
		while (pending.size() != 0)
			@(posedge CLK_PLL);
		@(posedge CLK_PLL);
		new_game    <= 1'b1;
		pins_count  <= pins;
		guesses_max <= max_guesses;
		@(posedge CLK_PLL);
		new_game <= 1'b0;
	endtask

	task automatic send_guess(input int gap, input pin_row_t secret_row, input pin_row_t guess_row,
			input logic drop, input hint_exp_t want);
		repeat (gap) begin
			@(posedge CLK_PLL);
			guess_valid <= 1'b0;
		end
		@(posedge CLK_PLL);
		guess_valid <= 1'b1;
		secret      <= secret_row;
		guess       <= guess_row;
		if (!drop) begin
			want.due = cycle + 4;   // cycle still holds the count from before this edge
			pending.push_back(want);
		end
	endtask

	// Outputs are settled at the falling edge
	always @(negedge CLK_PLL) begin
		hint_exp_t want;
		if (cycle > cycle_limit) begin
			$display("Timeout after %0d cycles before the test data was done", cycle);
			abort_run();
		end
		if (!reset && hint_valid) begin
			if (pending.size() == 0) begin
				$display("hint_valid went high at %0t with no scored guess outstanding", $time);
				abort_run();
			end else begin
				want = pending.pop_front();
				if (cycle != want.due) begin
					$display("ERR %0t hint_valid cycle expected %0d got %0d",
						$time, want.due, cycle);
					abort_run();
				end
				check_pins("green", want.green, green);
				check_pins("yellow", want.yellow, yellow);
				check_guesses("guess_number", want.number, guess_number);
				check_state("game_state", want.state, game_state);
			end
		end
	end

	initial begin
		int               fd;
		int               code;
		int               lines;
		byte              kind;
		logic [8*160-1:0] text;
		int               n_pins;
		int               n_max;
		int               gap;
		pin_row_t         secret_row;
		pin_row_t         guess_row;
		int               exp_green;
		int               exp_yellow;
		int               exp_number;
		logic [63:0]      word;
		game_state_t      exp_state;
		logic             drop;
		hint_exp_t        want;
		logic             done;

		reset       = 1'b1;
		new_game    = 1'b0;
		pins_count  = pin_count_t'(4);
		guesses_max = '1;
		secret      = '0;
		guess_valid = 1'b0;
		guess       = '0;
		cycle_limit = 50;

		// Cycle budget scales with the length of the data file
		fd = $fopen("verification/mastermind_tests.txt", "r");
		if (fd == 0) begin
			$display("Cannot open verification/mastermind_tests.txt");
			abort_run();
		end
		lines = 0;
		while ($fgets(text, fd) != 0)
			lines++;
		$fclose(fd);
		cycle_limit = 4 * lines + 50;
		fd = $fopen("verification/mastermind_tests.txt", "r");

		repeat (5) @(posedge CLK_PLL);
		reset <= 1'b0;

		done = 1'b0;
		while (!done) begin
			code = $fscanf(fd, " %c", kind);
			if (code != 1) begin
				done = 1'b1;
			end else if (kind == "#") begin
				code = $fgets(text, fd);   // Rest of a comment line
			end else if (kind == "N") begin
				code = $fscanf(fd, "%d %d", n_pins, n_max);
				if (code != 2) begin
					$display("Malformed new game line in the test data");
					abort_run();
				end else begin
					start_game(pin_count_t'(n_pins), guess_count_t'(n_max));
				end
			end else if (kind == "G") begin
				code = $fscanf(fd, "%d %h %h %d %d %d %s", gap, secret_row, guess_row,
					exp_green, exp_yellow, exp_number, word);
				if (code != 7 || !decode_state(word, exp_state, drop)) begin
					$display("Malformed guess line in the test data");
					abort_run();
				end else begin
					want.green  = pin_count_t'(exp_green);
					want.yellow = pin_count_t'(exp_yellow);
					want.number = guess_count_t'(exp_number);
					want.state  = exp_state;
					want.due    = 0;
					send_guess(gap, secret_row, guess_row, drop, want);
				end
			end else begin
				$display("Unknown command in the test data");
				abort_run();
			end
		end
		$fclose(fd);

		@(posedge CLK_PLL);
		guess_valid <= 1'b0;
		repeat (5) @(posedge CLK_PLL);   // Longer than the three cycle hint latency
		if (pending.size() != 0) begin
			$display("%0d expected hints never arrived", pending.size());
			abort_run();
		end else begin
			$display("RESULT: PASS");
			$finish;
		end
	end

endmodule

// File: verification/mastermind_tests.txt
# N pins_count guesses_max
# G gap secret_hex guess_hex green yellow guess_number state (playing, solved, lost or drop)
# Repeated colors, unused positions, back to back guesses, solved then dropped
N 4 10
G 0 00001123 00003211 0 4 1 playing
G 0 00001123 00002250 0 1 2 playing
G 1 00001123 00001111 2 0 3 playing
G 0 00001123 00001132 2 2 4 playing
G 0 00001123 98761132 2 2 5 playing
G 2 00001123 32111132 2 2 6 playing
G 0 00001123 ffff1123 4 0 7 solved
G 0 00001123 00001123 0 0 0 drop
G 2 00001123 00003211 0 0 0 drop
# Six pins, limit reached without solving
N 6 3
G 1 77654321 00123456 0 6 1 playing
G 0 77654321 00654777 3 0 2 playing
G 0 77654321 77111111 1 0 3 lost
G 0 77654321 77654321 0 0 0 drop
# Smallest row
N 2 4
G 0 00000035 00000053 0 2 1 playing
G 1 00000035 00000055 1 0 2 playing
G 0 00000035 12345635 2 0 3 solved
# Full row, lost on the second guess
N 8 2
G 0 12345678 87654321 0 8 1 playing
G 0 12345678 12345687 6 2 2 lost
G 1 12345678 12345678 0 0 0 drop
# New game in the middle of a game
N 3 5
G 0 00000aab 00000bba 0 2 1 playing
G 0 00000aab 00000cab 2 0 2 playing
N 3 5
G 0 00000aab 00000aab 3 0 1 solved
# Five pins with two colors only
N 5 4
G 0 00013131 00033333 2 0 1 playing
G 0 00013131 00011311 2 2 2 playing
G 2 00013131 00031313 0 4 3 playing
G 0 00013131 00013132 4 0 4 lost

// File: project.f
+incdir+logic
logic/mastermind_pkg.sv
logic/exact_matcher.sv
logic/color_tally.sv
logic/hint_combiner.sv
logic/mastermind_judge.sv
verification/mastermind_tb.sv

// File: run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module mastermind_tb -f project.f

./obj_dir/Vmastermind_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
	echo "Simulation failed"
	exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"
